// ==== logic/dma_settings.svh ====
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// number of cache banks sharing the memory
`define NUM_CACHE 4

// word width of every data lane
`define DATA_WIDTH 32

// words in one cache block
`define BLOCK_WORDS 4

// cache byte address carried in the dma packet
`define CACHE_ADDR_WIDTH 16

// words in each cache's private bank of memory
`define BANK_WORDS 256

`endif

// ==== logic/dma_pkt_pkg.sv ====
`include "dma_settings.svh"

package dma_pkt_pkg;

  // packet layout, msb first: {write_not_read, addr}
  localparam int pkt_addr_width = `CACHE_ADDR_WIDTH;
  localparam int pkt_addr_lsb   = 0;
  localparam int pkt_wnr_bit    = pkt_addr_lsb + pkt_addr_width;
  localparam int pkt_width      = pkt_wnr_bit + 1;

  // values of the wnr flag
  localparam logic op_write = 1'b1;
  localparam logic op_read  = 1'b0;

  // index of the requesting cache
  localparam int cache_id_width = $clog2(`NUM_CACHE);

endpackage

// ==== logic/mem_map_pkg.sv ====
`include "dma_settings.svh"

package mem_map_pkg;

  // bytes within a word, dropped by the mapper
  localparam int byte_off_width = $clog2(`DATA_WIDTH / 8);

  // word within a block
  localparam int word_off_width = $clog2(`BLOCK_WORDS);

  // block within one cache's bank
  localparam int blk_idx_width = $clog2(`BANK_WORDS) - word_off_width;

  // where the block index starts in the cache byte address
  localparam int blk_idx_lsb = byte_off_width + word_off_width;

  // flat word address over all banks
  localparam int mem_addr_width = dma_pkt_pkg::cache_id_width + blk_idx_width
                                  + word_off_width;

  // channel address, built by field and consumed as one word address
  typedef union packed {
    struct packed {
      logic [dma_pkt_pkg::cache_id_width-1:0] cache_id; // selects the bank
      logic [blk_idx_width-1:0]               blk_idx;
      logic [word_off_width-1:0]              word_off;
    } fields;
    logic [mem_addr_width-1:0] flat;
  } chan_addr_u;

endpackage

// ==== logic/dma_arbiter.sv ====
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_arbiter (
  input  logic                                             core_clk,
  input  logic                                             arst_n_i,
  input  logic [`NUM_CACHE-1:0][dma_pkt_pkg::pkt_width-1:0] dma_pkt_i,
  input  logic [`NUM_CACHE-1:0]                            dma_pkt_v_i,
  output logic [`NUM_CACHE-1:0]                            dma_pkt_yumi_o,
  input  logic                                             req_ready_i,
  output logic                                             req_v_o,
  output logic                                             req_wnr_o,
  output logic [dma_pkt_pkg::cache_id_width-1:0]           req_id_o,
  output logic [`CACHE_ADDR_WIDTH-1:0]                     req_addr_o
);

  localparam int id_w = dma_pkt_pkg::cache_id_width;

  logic [id_w-1:0]                   last_r; // last cache granted
  logic [id_w-1:0]                   cand;
  logic [id_w-1:0]                   gnt_id;
  logic                              gnt_found;
  logic                              take;
  logic [dma_pkt_pkg::pkt_width-1:0] gnt_pkt;

  // search starts at the cache after the last winner
  always_comb begin
    gnt_found = 1'b0;
    gnt_id = last_r;
    cand = last_r;
    for (int i = 1; i <= `NUM_CACHE; i++) begin
      cand = id_w'((int'(last_r) + i) % `NUM_CACHE);
      if (!gnt_found && dma_pkt_v_i[cand]) begin
        gnt_found = 1'b1;
        gnt_id = cand;
      end
    end
  end

  // output stage takes a packet when empty or draining this cycle
  assign take = gnt_found && (!req_v_o || req_ready_i);
  assign gnt_pkt = dma_pkt_i[gnt_id];

  always_comb begin
    dma_pkt_yumi_o = '0;
    dma_pkt_yumi_o[gnt_id] = take;
  end

  always_ff @(posedge core_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_v_o <= 1'b0;
      last_r <= id_w'(`NUM_CACHE - 1); // first search begins at cache 0
    end else if (take) begin
      req_v_o <= 1'b1;
      last_r <= gnt_id; // pointer moves only on a grant
    end else if (req_ready_i) begin
      req_v_o <= 1'b0;
    end
  end

  always_ff @(posedge core_clk) begin
    if (take) begin
      req_wnr_o <= (gnt_pkt[dma_pkt_pkg::pkt_wnr_bit] == dma_pkt_pkg::op_write);
      req_id_o <= gnt_id;
      req_addr_o <= gnt_pkt[dma_pkt_pkg::pkt_addr_lsb +: dma_pkt_pkg::pkt_addr_width];
    end
  end

endmodule

// ==== logic/addr_mapper.sv ====
`timescale 1ns/1ps
`include "dma_settings.svh"

module addr_mapper (
  input  logic                                   core_clk,
  input  logic                                   arst_n_i,
  input  logic                                   req_v_i,
  input  logic                                   req_wnr_i,
  input  logic [dma_pkt_pkg::cache_id_width-1:0] req_id_i,
  input  logic [`CACHE_ADDR_WIDTH-1:0]           req_addr_i,
  output logic                                   req_ready_o,
  output logic                                   map_v_o,
  output logic                                   map_wnr_o,
  output mem_map_pkg::chan_addr_u                map_addr_o,
  input  logic                                   map_ready_i
);

  logic                    accept;
  mem_map_pkg::chan_addr_u nxt_addr;

  assign req_ready_o = !map_v_o || map_ready_i;
  assign accept = req_v_i && req_ready_o;

  // byte offset and bits above the bank size fall away
  always_comb begin
    nxt_addr = '0; // word offset zero, block aligned
    nxt_addr.fields.cache_id = req_id_i;
    nxt_addr.fields.blk_idx =
      req_addr_i[mem_map_pkg::blk_idx_lsb +: mem_map_pkg::blk_idx_width];
  end

  always_ff @(posedge core_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      map_v_o <= 1'b0;
    end else if (accept) begin
      map_v_o <= 1'b1;
    end else if (map_ready_i) begin
      map_v_o <= 1'b0;
    end
  end

  always_ff @(posedge core_clk) begin
    if (accept) begin
      map_wnr_o <= req_wnr_i;
      map_addr_o <= nxt_addr;
    end
  end

endmodule

// ==== logic/block_mem.sv ====
`timescale 1ns/1ps
`include "dma_settings.svh"

module block_mem (
  input  logic                                  core_clk,
  input  logic                                  arst_n_i,
  input  logic                                  map_v_i,
  input  logic                                  map_wnr_i,
  input  mem_map_pkg::chan_addr_u               map_addr_i,
  output logic                                  map_ready_o,
  input  logic [`NUM_CACHE-1:0][`DATA_WIDTH-1:0] dma_data_i,
  input  logic [`NUM_CACHE-1:0]                 dma_data_v_i,
  output logic [`NUM_CACHE-1:0]                 dma_data_yumi_o,
  output logic [`DATA_WIDTH-1:0]                dma_data_o,
  output logic [`NUM_CACHE-1:0]                 dma_data_v_o,
  input  logic [`NUM_CACHE-1:0]                 dma_data_ready_i
);

  localparam int aw   = mem_map_pkg::mem_addr_width;
  localparam int ow   = mem_map_pkg::word_off_width;
  localparam int id_w = dma_pkt_pkg::cache_id_width;

  logic [`DATA_WIDTH-1:0] mem [0:`NUM_CACHE*`BANK_WORDS-1];

  // sequencer state
  logic            busy_r;
  logic [ow-1:0]   beat_r;
  logic            wnr_r;
  logic [id_w-1:0] id_r;
  logic [aw-1:0]   base_r;

  logic                   rd_mode;
  logic                   beat_fire;
  logic                   last_beat;
  logic                   accept;
  logic [aw-1:0]          cur_addr;
  logic [aw-1:0]          nxt_addr;
  logic [`DATA_WIDTH-1:0] rdata_r;

  assign rd_mode = (wnr_r == dma_pkt_pkg::op_read);

  // one word moves per beat, from or to the owning cache only
  assign beat_fire = busy_r && (rd_mode ? dma_data_ready_i[id_r] : dma_data_v_i[id_r]);
  assign last_beat = beat_fire && (beat_r == ow'(`BLOCK_WORDS - 1));

  assign map_ready_o = !busy_r || last_beat;
  assign accept = map_v_i && map_ready_o;

  // base is block aligned so or-ing in the offset is enough
  assign cur_addr = base_r | aw'(beat_r);
  assign nxt_addr = base_r | aw'(ow'(beat_r + 1'b1));

  always_comb begin
    dma_data_yumi_o = '0;
    dma_data_v_o = '0;
    dma_data_yumi_o[id_r] = busy_r && !rd_mode && dma_data_v_i[id_r];
    dma_data_v_o[id_r] = busy_r && rd_mode;
  end

  assign dma_data_o = rdata_r;

  always_ff @(posedge core_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_r <= 1'b0;
      beat_r <= '0;
    end else if (accept) begin
      busy_r <= 1'b1; // back to back blocks keep busy high
      beat_r <= '0;
    end else if (beat_fire) begin
      beat_r <= beat_r + 1'b1;
      if (last_beat) begin
        busy_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge core_clk) begin
    if (accept) begin
      wnr_r <= map_wnr_i;
      id_r <= map_addr_i.fields.cache_id;
      base_r <= map_addr_i.flat;
    end
  end

  always_ff @(posedge core_clk) begin
    if (beat_fire && !rd_mode) begin
      mem[cur_addr] <= dma_data_i[id_r];
    end
  end

  // read word held until the cache takes it
  always_ff @(posedge core_clk) begin
    if (accept) begin
      rdata_r <= mem[map_addr_i.flat];
    end else if (beat_fire && rd_mode) begin
      rdata_r <= mem[nxt_addr];
    end
  end

endmodule

// ==== logic/dma_mem_bridge.sv ====
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_mem_bridge (
  input  logic                                             core_clk,
  input  logic                                             arst_n_i,
  input  logic [`NUM_CACHE-1:0][dma_pkt_pkg::pkt_width-1:0] dma_pkt_i,
  input  logic [`NUM_CACHE-1:0]                            dma_pkt_v_i,
  output logic [`NUM_CACHE-1:0]                            dma_pkt_yumi_o,
  input  logic [`NUM_CACHE-1:0][`DATA_WIDTH-1:0]           dma_data_i,
  input  logic [`NUM_CACHE-1:0]                            dma_data_v_i,
  output logic [`NUM_CACHE-1:0]                            dma_data_yumi_o,
  output logic [`DATA_WIDTH-1:0]                           dma_data_o,
  output logic [`NUM_CACHE-1:0]                            dma_data_v_o,
  input  logic [`NUM_CACHE-1:0]                            dma_data_ready_i
);

  // arbiter to mapper
  logic                                   req_v;
  logic                                   req_wnr;
  logic [dma_pkt_pkg::cache_id_width-1:0] req_id;
  logic [`CACHE_ADDR_WIDTH-1:0]           req_addr;
  logic                                   req_ready;

  // mapper to memory
  logic                    map_v;
  logic                    map_wnr;
  mem_map_pkg::chan_addr_u map_addr;
  logic                    map_ready;

  dma_arbiter arb (
    .core_clk       (core_clk),
    .arst_n_i       (arst_n_i),
    .dma_pkt_i      (dma_pkt_i),
    .dma_pkt_v_i    (dma_pkt_v_i),
    .dma_pkt_yumi_o (dma_pkt_yumi_o),
    .req_ready_i    (req_ready),
    .req_v_o        (req_v),
    .req_wnr_o      (req_wnr),
    .req_id_o       (req_id),
    .req_addr_o     (req_addr)
  );

  addr_mapper mapper (
    .core_clk    (core_clk),
    .arst_n_i    (arst_n_i),
    .req_v_i     (req_v),
    .req_wnr_i   (req_wnr),
    .req_id_i    (req_id),
    .req_addr_i  (req_addr),
    .req_ready_o (req_ready),
    .map_v_o     (map_v),
    .map_wnr_o   (map_wnr),
    .map_addr_o  (map_addr),
    .map_ready_i (map_ready)
  );

  block_mem mem (
    .core_clk         (core_clk),
    .arst_n_i         (arst_n_i),
    .map_v_i          (map_v),
    .map_wnr_i        (map_wnr),
    .map_addr_i       (map_addr),
    .map_ready_o      (map_ready),
    .dma_data_i       (dma_data_i),
    .dma_data_v_i     (dma_data_v_i),
    .dma_data_yumi_o  (dma_data_yumi_o),
    .dma_data_o       (dma_data_o),
    .dma_data_v_o     (dma_data_v_o),
    .dma_data_ready_i (dma_data_ready_i)
  );

endmodule

// ==== testbench/dma_mem_assertions.sv ====
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_mem_assertions (
  input logic                 core_clk,
  input logic                 arst_n_i,
  input logic [`NUM_CACHE-1:0] dma_pkt_v_i,
  input logic [`NUM_CACHE-1:0] dma_pkt_yumi_o,
  input logic [`NUM_CACHE-1:0] dma_data_v_i,
  input logic [`NUM_CACHE-1:0] dma_data_yumi_o,
  input logic [`DATA_WIDTH-1:0] dma_data_o,
  input logic [`NUM_CACHE-1:0] dma_data_v_o,
  input logic [`NUM_CACHE-1:0] dma_data_ready_i
);

  int unsigned fail_cnt = 0;

  // nothing leaves the bridge while reset is held
  reset_idle: assert property (@(posedge core_clk)
    !arst_n_i |-> (dma_pkt_yumi_o == '0 && dma_data_yumi_o == '0 && dma_data_v_o == '0))
    else begin fail_cnt++; $error("outputs active during reset"); end

  pkt_yumi_legal: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    ((dma_pkt_yumi_o & ~dma_pkt_v_i) == '0) && $onehot0(dma_pkt_yumi_o))
    else begin fail_cnt++; $error("packet yumi without valid or to several caches"); end

  wr_yumi_legal: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    ((dma_data_yumi_o & ~dma_data_v_i) == '0) && $onehot0(dma_data_yumi_o))
    else begin fail_cnt++; $error("write yumi without valid or to several caches"); end

  rd_valid_onehot: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    $onehot0(dma_data_v_o))
    else begin fail_cnt++; $error("read valid raised for several caches"); end

  // read and write bursts never overlap
  rd_wr_exclusive: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    !((|dma_data_v_o) && (|dma_data_yumi_o)))
    else begin fail_cnt++; $error("read and write beats in the same cycle"); end

  // stalled read word frozen
  rd_hold: assert property (@(posedge core_clk) disable iff (!arst_n_i)
    (|(dma_data_v_o & ~dma_data_ready_i)) |=> ($stable(dma_data_v_o) && $stable(dma_data_o)))
    else begin fail_cnt++; $error("read word changed while stalled"); end

endmodule

bind dma_mem_bridge dma_mem_assertions bridge_checks (
  .core_clk         (core_clk),
  .arst_n_i         (arst_n_i),
  .dma_pkt_v_i      (dma_pkt_v_i),
  .dma_pkt_yumi_o   (dma_pkt_yumi_o),
  .dma_data_v_i     (dma_data_v_i),
  .dma_data_yumi_o  (dma_data_yumi_o),
  .dma_data_o       (dma_data_o),
  .dma_data_v_o     (dma_data_v_o),
  .dma_data_ready_i (dma_data_ready_i)
);

// ==== testbench/dma_mem_tb.sv ====
`timescale 1ns/1ps
`include "dma_settings.svh"

module dma_mem_tb;

  localparam int NC          = `NUM_CACHE;
  localparam int DW          = `DATA_WIDTH;
  localparam int BW          = `BLOCK_WORDS;
  localparam int AW          = `CACHE_ADDR_WIDTH;
  localparam int PKT_W       = AW + 1;
  localparam int PER_CACHE   = 24;
  localparam int NUM_TESTS   = NC * PER_CACHE;
  localparam int TIMEOUT     = NUM_TESTS * 4 * (BW + 8);
  localparam int BLOCK_BYTES = BW * DW / 8;
  localparam int BANK_BLOCKS = `BANK_WORDS / BW;
  localparam int BANK_BYTES  = BANK_BLOCKS * BLOCK_BYTES;
  localparam logic [AW-1:0] SHARED_ADDR = AW'('h1234);

  logic                     core_clk;
  logic                     arst_n_i;
  logic [NC-1:0][PKT_W-1:0] dma_pkt_i;
  logic [NC-1:0]            dma_pkt_v_i;
  logic [NC-1:0]            dma_pkt_yumi_o;
  logic [NC-1:0][DW-1:0]    dma_data_i;
  logic [NC-1:0]            dma_data_v_i;
  logic [NC-1:0]            dma_data_yumi_o;
  logic [DW-1:0]            dma_data_o;
  logic [NC-1:0]            dma_data_v_o;
  logic [NC-1:0]            dma_data_ready_i;

  // per cache traffic built before reset
  logic [PKT_W-1:0] pkt_arr [NC][PER_CACHE];
  logic [DW-1:0]    wr_arr  [NC][PER_CACHE*BW];
  logic [DW-1:0]    exp_arr [NC][PER_CACHE*BW];
  int pkt_cnt [NC];
  int pkt_head [NC];
  int wr_cnt [NC];
  int wr_head [NC];
  int exp_cnt [NC];
  int exp_head [NC];
  int wr_credit [NC]; // write words still owed
  int rd_credit [NC]; // read words still owed
  int wait_cnt [NC];  // grants to others while waiting

  // reference memory with one bank per cache
  logic [DW-1:0] ref_mem [NC][BANK_BLOCKS][BW];
  logic          written [NC][BANK_BLOCKS];

  logic [31:0] lfsr_q;
  int          check_errs;
  int          cycles;

  dma_mem_bridge UUT (
    .core_clk         (core_clk),
    .arst_n_i         (arst_n_i),
    .dma_pkt_i        (dma_pkt_i),
    .dma_pkt_v_i      (dma_pkt_v_i),
    .dma_pkt_yumi_o   (dma_pkt_yumi_o),
    .dma_data_i       (dma_data_i),
    .dma_data_v_i     (dma_data_v_i),
    .dma_data_yumi_o  (dma_data_yumi_o),
    .dma_data_o       (dma_data_o),
    .dma_data_v_o     (dma_data_v_o),
    .dma_data_ready_i (dma_data_ready_i)
  );

  initial begin
    core_clk = 1'b0;
    forever #2 core_clk = ~core_clk;
  end

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  task automatic add_packet(input int c, input logic wnr, input logic [AW-1:0] addr);
    int            blk;
    logic [31:0]   r;
    logic [DW-1:0] d;
    blk = (int'(addr) / BLOCK_BYTES) % BANK_BLOCKS; // upper bits wrap
    pkt_arr[c][pkt_cnt[c]] = {wnr, addr};
    pkt_cnt[c]++;
    for (int w = 0; w < BW; w++) begin
      if (wnr) begin
        r = rand_bits(DW - 8);
        d = {8'(c), r[DW-9:0]}; // top byte tags the owner
        ref_mem[c][blk][w] = d;
        wr_arr[c][wr_cnt[c]] = d;
        wr_cnt[c]++;
      end else begin
        exp_arr[c][exp_cnt[c]] = ref_mem[c][blk][w];
        exp_cnt[c]++;
      end
    end
    if (wnr) begin
      written[c][blk] = 1'b1;
    end
  endtask

  task automatic build_traffic();
    logic [31:0] r;
    logic [31:0] op;
    int          a;
    int          blk;
    // every cache hits the same address and banks keep them apart
    for (int c = 0; c < NC; c++) begin
      add_packet(c, 1'b1, SHARED_ADDR);
      add_packet(c, 1'b0, SHARED_ADDR);
    end
    for (int c = 0; c < NC; c++) begin
      for (int i = 2; i < PER_CACHE; i++) begin
        r = rand_bits(AW);
        blk = int'(rand_bits(3));
        op = rand_bits(1);
        a = int'(r[AW-1:0]);
        a = a - a % BANK_BYTES + blk * BLOCK_BYTES + a % BLOCK_BYTES;
        add_packet(c, op[0] || !written[c][blk], AW'(a));
      end
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    for (int c = 0; c < NC; c++) begin
      r = rand_bits(3);
      dma_pkt_v_i[c] = (pkt_head[c] < pkt_cnt[c]);
      if (dma_pkt_v_i[c]) begin
        dma_pkt_i[c] = pkt_arr[c][pkt_head[c]];
      end
      dma_data_v_i[c] = (wr_credit[c] > 0) && r[0]; // gaps on the write lane
      if (wr_credit[c] > 0) begin
        dma_data_i[c] = wr_arr[c][wr_head[c]];
      end
      dma_data_ready_i[c] = r[1] | r[2];
    end
  endtask

  task automatic sample_outputs();
    for (int c = 0; c < NC; c++) begin
      if (dma_data_yumi_o[c]) begin
        assert (wr_credit[c] > 0) else begin
          $display("write yumi to cache %0d with no write block open", c);
          check_errs++;
        end
        if (wr_credit[c] > 0) begin
          wr_credit[c]--;
          wr_head[c]++;
        end
      end
      if (dma_data_v_o[c]) begin
        assert (rd_credit[c] > 0) else begin
          $display("read valid to cache %0d with no read block open", c);
          check_errs++;
        end
        if (dma_data_ready_i[c] && rd_credit[c] > 0) begin
          assert (dma_data_o == exp_arr[c][exp_head[c]]) else begin
            $display("FAILED dma_data_o to cache %0d: got 0x%h expected 0x%h",
                     c, dma_data_o, exp_arr[c][exp_head[c]]);
            check_errs++;
          end
          rd_credit[c]--;
          exp_head[c]++;
        end
      end
    end
    for (int c = 0; c < NC; c++) begin
      if (dma_pkt_yumi_o[c] && dma_pkt_v_i[c]) begin
        wait_cnt[c] = 0;
        for (int d = 0; d < NC; d++) begin
          if (d != c && dma_pkt_v_i[d]) begin
            wait_cnt[d]++;
            assert (wait_cnt[d] < NC) else begin
              $display("cache %0d passed over by %0d grants in a row", d, wait_cnt[d]);
              check_errs++;
            end
          end
        end
        if (pkt_arr[c][pkt_head[c]][AW]) begin
          wr_credit[c] += BW;
        end else begin
          rd_credit[c] += BW;
        end
        pkt_head[c]++;
      end
    end
  endtask

  function automatic bit traffic_done();
    for (int c = 0; c < NC; c++) begin
      if (pkt_head[c] < pkt_cnt[c] || wr_credit[c] != 0 || rd_credit[c] != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic check_idle(input string when);
    assert (dma_pkt_yumi_o == '0 && dma_data_yumi_o == '0 && dma_data_v_o == '0) else begin
      $display("FAILED %s: dma_pkt_yumi_o=0x%h dma_data_yumi_o=0x%h dma_data_v_o=0x%h",
               when, dma_pkt_yumi_o, dma_data_yumi_o, dma_data_v_o);
      check_errs++;
    end
  endtask

  initial begin
    cycles = 0;
    forever begin
      @(posedge core_clk);
      cycles++;
      if (cycles >= TIMEOUT) begin
        $display("timeout after %0d cycles, traffic never drained", cycles);
        $display("*** TEST FAILED ***");
        $finish;
      end
    end
  end

  initial begin
    arst_n_i = 1'b0;
    dma_pkt_i = '0;
    dma_pkt_v_i = '0;
    dma_data_i = '0;
    dma_data_v_i = '0;
    dma_data_ready_i = '0;
    lfsr_q = 32'd79266;
    check_errs = 0;
    for (int c = 0; c < NC; c++) begin
      pkt_cnt[c] = 0;
      pkt_head[c] = 0;
      wr_cnt[c] = 0;
      wr_head[c] = 0;
      exp_cnt[c] = 0;
      exp_head[c] = 0;
      wr_credit[c] = 0;
      rd_credit[c] = 0;
      wait_cnt[c] = 0;
      for (int b = 0; b < BANK_BLOCKS; b++) begin
        written[c][b] = 1'b0;
      end
    end
    build_traffic();
    repeat (4) @(posedge core_clk);
    @(negedge core_clk);
    arst_n_i = 1'b1;
    repeat (3) begin
      @(negedge core_clk);
      #1;
      check_idle("idle after reset");
    end
    while (!traffic_done()) begin
      @(negedge core_clk);
      drive_inputs();
      #1;
      sample_outputs();
    end
    @(negedge core_clk);
    dma_pkt_v_i = '0;
    dma_data_v_i = '0;
    dma_data_ready_i = '1;
    repeat (2) @(negedge core_clk);
    #1;
    check_idle("idle after traffic");
    $display("errors: %0d testbench checks, %0d bound assertions over %0d packets",
             check_errs, UUT.bridge_checks.fail_cnt, NUM_TESTS);
    if (check_errs == 0 && UUT.bridge_checks.fail_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/dma_pkt_pkg.sv
logic/mem_map_pkg.sv
logic/dma_arbiter.sv
logic/addr_mapper.sv
logic/block_mem.sv
logic/dma_mem_bridge.sv
testbench/dma_mem_assertions.sv
testbench/dma_mem_tb.sv

// ==== Makefile ====
# Verilator flow for the DMA memory bridge

TOP = dma_mem_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f verilog.f --top-module $(TOP)

# pass only if the pass message shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
